// ==== hdl/icache_pkg.sv ====
package icache_pkg;

    // core side is word addressed, one word is one instruction
    localparam int CORE_ADDR_W = 16;
    localparam int CORE_DATA_W = 32;

    // memory side, one beat carries four instruction words
    localparam int MEM_DATA_W = 128;
    // beat address is the core word address without its two lowest bits
    localparam int MEM_ADDR_W = CORE_ADDR_W - 2;

    // 64 byte line
    localparam int LINE_WORDS = 16;
    localparam int LINE_DATA_W = LINE_WORDS * CORE_DATA_W;
    localparam int BEATS_PER_LINE = LINE_DATA_W / MEM_DATA_W;
    // width of a beat number inside a line
    localparam int BEAT_W = $clog2(BEATS_PER_LINE);

    // direct-mapped array, SETS has to be a power of two
    localparam int SETS = 8;

    // address split, tag | index | offset
    localparam int OFFSET_W = $clog2(LINE_WORDS);
    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W = CORE_ADDR_W - INDEX_W - OFFSET_W;

    // fetch request from the core
    typedef struct packed {
        logic [CORE_ADDR_W-1:0] addr;
    } core_req_t;

    // instruction returned to the core
    typedef struct packed {
        logic [CORE_DATA_W-1:0] data;
    } core_rsp_t;

    // one beat read toward main memory
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
    } mem_req_t;

    // one beat of line data back from main memory
    typedef struct packed {
        logic [MEM_DATA_W-1:0] data;
    } mem_rsp_t;

    // field order matches the bit order of a core word address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // refill controller states
    typedef enum logic [1:0] {
        ST_RESET = 2'd0,
        ST_READY = 2'd1,
        ST_MISS  = 2'd2
    } refill_state_t;

endpackage

// ==== hdl/icache_tag_lookup.sv ====
`timescale 1ns/1ps

module icache_tag_lookup (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_fire,
    input  icache_pkg::core_req_t           core_req,
    input  logic                            fill_done,
    input  logic [icache_pkg::INDEX_W-1:0]  fill_index,
    input  logic [icache_pkg::TAG_W-1:0]    fill_tag,
    output logic                            lookup_valid,
    output logic                            lookup_hit,
    output icache_pkg::addr_fields_t        lookup_addr
);

    // incoming address seen as tag, index and word offset
    icache_pkg::addr_fields_t req_fields;

    // tag store, one entry per set
    logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::SETS];
    // one valid bit per set
    logic [icache_pkg::SETS-1:0] valid_q;

    logic tag_match;
    logic hit_c;

    assign req_fields = icache_pkg::addr_fields_t'(core_req.addr);

    // compare against the indexed set
    assign tag_match = (tag_mem[req_fields.index] == req_fields.tag);
    assign hit_c = valid_q[req_fields.index] && tag_match;

    // valid bits, all lines invalid out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_done) begin
            // line is complete once the last beat has landed
            valid_q[fill_index] <= 1'b1;
        end
    end

    // new tag written together with the valid bit
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[fill_index] <= fill_tag;
        end
    end

    // lookup result lands one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_valid <= 1'b0;
            lookup_hit <= 1'b0;
        end else begin
            lookup_valid <= req_fire;
            // hit only meaningful with a request behind it
            lookup_hit <= req_fire && hit_c;
        end
    end

    // address fields of the accepted request
    always_ff @(posedge clk) begin
        if (req_fire) begin
            lookup_addr <= req_fields;
        end
    end

    // a refill only follows a miss, and the core is stalled meanwhile,
    // so a hit result can never be in flight when a line is completed
    a_no_fill_on_hit: assert property (
        @(posedge clk) disable iff (rst)
        fill_done |-> !(lookup_valid && lookup_hit)
    );

endmodule

// ==== hdl/icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lookup_valid,
    input  logic                            lookup_hit,
    input  icache_pkg::addr_fields_t        lookup_addr,
    input  logic                            mem_rsp_valid,
    output logic                            core_req_ready,
    output logic                            mem_req_valid,
    output icache_pkg::mem_req_t            mem_req,
    output logic                            fill_beat_valid,
    output logic [icache_pkg::BEAT_W-1:0]   fill_beat_num,
    output logic [icache_pkg::INDEX_W-1:0]  fill_index,
    output logic [icache_pkg::TAG_W-1:0]    fill_tag,
    output logic                            fill_done,
    output logic                            rsp_sel_valid,
    output icache_pkg::addr_fields_t        rsp_sel_addr
);

    icache_pkg::refill_state_t state;
    icache_pkg::refill_state_t state_nx;

    // registered lookup that missed
    logic miss_detect;

    // request waiting for its line
    logic pend_valid;
    icache_pkg::addr_fields_t pend_addr;

    // beat requests issued, one spare bit so overrun is observable
    logic [icache_pkg::BEAT_W:0] req_cnt;
    // beat responses received
    logic [icache_pkg::BEAT_W-1:0] rsp_cnt;

    // line of the beat being requested
    icache_pkg::addr_fields_t line_addr;

    assign miss_detect = lookup_valid && !lookup_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::ST_RESET;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            icache_pkg::ST_RESET: state_nx = icache_pkg::ST_READY;
            icache_pkg::ST_READY: begin
                if (miss_detect) begin
                    state_nx = icache_pkg::ST_MISS;
                end
            end
            // back to ready on the edge after the last beat
            icache_pkg::ST_MISS: begin
                if (fill_done) begin
                    state_nx = icache_pkg::ST_READY;
                end
            end
            default: state_nx = icache_pkg::ST_RESET;
        endcase
    end

    // pending request, captured in the cycle the miss is seen
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if (state == icache_pkg::ST_READY) begin
            // served in the first ready cycle after the fill
            pend_valid <= miss_detect && !pend_valid;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == icache_pkg::ST_READY) && miss_detect) begin
            pend_addr <= lookup_addr;
        end
    end

    // request side counter, wraps after the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            req_cnt <= '0;
        end else if (mem_req_valid) begin
            if (req_cnt == icache_pkg::BEATS_PER_LINE - 1) begin
                req_cnt <= '0;
            end else begin
                req_cnt <= req_cnt + 1'b1;
            end
        end
    end

    // response side counter, beats come back in request order
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_cnt <= '0;
        end else if (fill_beat_valid) begin
            rsp_cnt <= rsp_cnt + 1'b1;
        end
    end

    // beat 0 leaves straight from the lookup, later beats use the pending copy
    assign line_addr = (state == icache_pkg::ST_READY) ? lookup_addr : pend_addr;

    always_comb begin
        core_req_ready = 1'b0;
        mem_req_valid = 1'b0;
        case (state)
            icache_pkg::ST_READY: begin
                // stall in the same cycle the miss shows up
                core_req_ready = !miss_detect;
                mem_req_valid = miss_detect;
            end
            icache_pkg::ST_MISS: begin
                // req_cnt back at zero means all beats are out
                mem_req_valid = (req_cnt != '0);
            end
            default: ;
        endcase
    end

    assign mem_req.addr = {line_addr.tag, line_addr.index, req_cnt[icache_pkg::BEAT_W-1:0]};

    // fill side toward the line store and tag array
    assign fill_beat_valid = (state == icache_pkg::ST_MISS) && mem_rsp_valid;
    assign fill_beat_num = rsp_cnt;
    assign fill_index = pend_addr.index;
    assign fill_tag = pend_addr.tag;
    assign fill_done = fill_beat_valid && (rsp_cnt == icache_pkg::BEATS_PER_LINE - 1);

    // pending word first, otherwise the registered hit
    assign rsp_sel_valid = (state == icache_pkg::ST_READY) && (pend_valid || lookup_hit);
    assign rsp_sel_addr = pend_valid ? pend_addr : lookup_addr;

    a_no_mem_req_in_reset: assert property (
        @(posedge clk) disable iff (rst)
        (state == icache_pkg::ST_RESET) |-> !mem_req_valid
    );

    a_req_cnt_in_range: assert property (
        @(posedge clk) disable iff (rst)
        req_cnt <= icache_pkg::BEATS_PER_LINE - 1
    );

endmodule

// ==== hdl/icache_line_store.sv ====
`timescale 1ns/1ps

module icache_line_store (
    input  logic                            clk,
    input  logic                            fill_beat_valid,
    input  logic [icache_pkg::INDEX_W-1:0]  fill_index,
    input  logic [icache_pkg::BEAT_W-1:0]   fill_beat_num,
    input  icache_pkg::mem_rsp_t            mem_rsp,
    input  logic                            rsp_sel_valid,
    input  icache_pkg::addr_fields_t        rsp_sel_addr,
    output logic                            core_rsp_valid,
    output icache_pkg::core_rsp_t           core_rsp
);

    // one line, seen as memory beats for writing and as words for reading
    typedef union packed {
        logic [icache_pkg::BEATS_PER_LINE-1:0][icache_pkg::MEM_DATA_W-1:0] beat;
        logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::CORE_DATA_W-1:0] word;
    } line_data_t;

    line_data_t line_mem [icache_pkg::SETS];

    // line being read for the response
    line_data_t sel_line;
    logic [icache_pkg::CORE_DATA_W-1:0] sel_word;

    // one beat slot per fill strobe, rest of the line untouched
    always_ff @(posedge clk) begin
        if (fill_beat_valid) begin
            line_mem[fill_index].beat[fill_beat_num] <= mem_rsp.data;
        end
    end

    // word select
    assign sel_line = line_mem[rsp_sel_addr.index];
    assign sel_word = sel_line.word[rsp_sel_addr.offset];

    // response strobe follows the selection in the same cycle
    assign core_rsp_valid = rsp_sel_valid;
    // data held at zero between responses
    assign core_rsp.data = rsp_sel_valid ? sel_word : '0;

    // beat number comes from the refill response counter
    a_fill_beat_known: assert property (
        @(posedge clk)
        fill_beat_valid |-> !$isunknown(fill_beat_num)
    );

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                    clk,
    input  logic                    rst,
    // core fetch request, valid/ready
    input  logic                    core_req_valid,
    input  icache_pkg::core_req_t   core_req,
    output logic                    core_req_ready,
    // core response strobe
    output logic                    core_rsp_valid,
    output icache_pkg::core_rsp_t   core_rsp,
    // memory beat request strobe
    output logic                    mem_req_valid,
    output icache_pkg::mem_req_t    mem_req,
    // memory beat response strobe
    input  logic                    mem_rsp_valid,
    input  icache_pkg::mem_rsp_t    mem_rsp
);

    logic req_fire;

    // lookup result
    logic lookup_valid;
    logic lookup_hit;
    icache_pkg::addr_fields_t lookup_addr;

    // refill toward the arrays
    logic fill_beat_valid;
    logic [icache_pkg::BEAT_W-1:0] fill_beat_num;
    logic [icache_pkg::INDEX_W-1:0] fill_index;
    logic [icache_pkg::TAG_W-1:0] fill_tag;
    logic fill_done;

    // which word goes back to the core
    logic rsp_sel_valid;
    icache_pkg::addr_fields_t rsp_sel_addr;

    // request transfers when both sides agree
    assign req_fire = core_req_valid && core_req_ready;

    icache_tag_lookup tag_lookup0 (
        .clk          (clk),
        .rst          (rst),
        .req_fire     (req_fire),
        .core_req     (core_req),
        .fill_done    (fill_done),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .lookup_valid (lookup_valid),
        .lookup_hit   (lookup_hit),
        .lookup_addr  (lookup_addr)
    );

    icache_refill refill0 (
        .clk             (clk),
        .rst             (rst),
        .lookup_valid    (lookup_valid),
        .lookup_hit      (lookup_hit),
        .lookup_addr     (lookup_addr),
        .mem_rsp_valid   (mem_rsp_valid),
        .core_req_ready  (core_req_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .fill_beat_valid (fill_beat_valid),
        .fill_beat_num   (fill_beat_num),
        .fill_index      (fill_index),
        .fill_tag        (fill_tag),
        .fill_done       (fill_done),
        .rsp_sel_valid   (rsp_sel_valid),
        .rsp_sel_addr    (rsp_sel_addr)
    );

    icache_line_store line_store0 (
        .clk             (clk),
        .fill_beat_valid (fill_beat_valid),
        .fill_index      (fill_index),
        .fill_beat_num   (fill_beat_num),
        .mem_rsp         (mem_rsp),
        .rsp_sel_valid   (rsp_sel_valid),
        .rsp_sel_addr    (rsp_sel_addr),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp        (core_rsp)
    );

endmodule

// ==== tests/icache_mem_model.sv ====
`timescale 1ns/1ps

module icache_mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_req_valid,
    input  icache_pkg::mem_req_t  mem_req,
    output logic                  mem_rsp_valid,
    output icache_pkg::mem_rsp_t  mem_rsp
);

    localparam int words_per_beat = icache_pkg::MEM_DATA_W / icache_pkg::CORE_DATA_W;

    // word a holds a times the golden ratio constant, marked in the upper half
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'hc0de_0000;
    endfunction

    // beat b carries words 4b to 4b+3, lowest word in the lowest bits
    function automatic logic [icache_pkg::MEM_DATA_W-1:0] beat_at(
        input logic [icache_pkg::MEM_ADDR_W-1:0] b
    );
        logic [icache_pkg::MEM_DATA_W-1:0] data;
        for (int k = 0; k < words_per_beat; k++) begin
            data[32*k +: 32] = word_at(32'(b) * words_per_beat + 32'(k));
        end
        return data;
    endfunction

    // quiet bus until the first clock edge
    initial begin
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
    end

    // always ready, every beat answered on the next edge
    always @(posedge clk) begin
        if (rst) begin
            mem_rsp_valid <= 1'b0;
            mem_rsp <= '0;
        end else begin
            mem_rsp_valid <= mem_req_valid;
            if (mem_req_valid) begin
                mem_rsp.data <= beat_at(mem_req.addr);
            end
        end
    end

endmodule

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    typedef logic [icache_pkg::CORE_ADDR_W-1:0] word_addr_t;
    typedef logic [icache_pkg::MEM_ADDR_W-1:0] beat_addr_t;

    // worst case per test allows about six cycles per miss plus margin
    localparam int reset_cycles = 3;
    localparam int test_cycles = 8 + 12 + 20 + 24 + 40 * 12;
    localparam int max_cycles = 2 * (reset_cycles + test_cycles);
    // 64 lines of 16 words
    localparam int rand_addr_bits = 10;
    localparam word_addr_t home_addr = 16'h1234;
    // same index with the next tag
    localparam word_addr_t evict_addr = home_addr + icache_pkg::SETS * icache_pkg::LINE_WORDS;

    logic clk = 1'b0;
    logic rst;
    logic core_req_valid;
    icache_pkg::core_req_t core_req;
    logic core_req_ready;
    logic core_rsp_valid;
    icache_pkg::core_rsp_t core_rsp;
    logic mem_req_valid;
    icache_pkg::mem_req_t mem_req;
    logic mem_rsp_valid;
    icache_pkg::mem_rsp_t mem_rsp;

    // requests sent and the responses and beat requests seen
    word_addr_t sent_q[$];
    logic [31:0] rsp_q[$];
    beat_addr_t beat_q[$];

    // tags per set as the testbench expects them
    logic [icache_pkg::TAG_W-1:0] model_tag [icache_pkg::SETS];
    logic [icache_pkg::SETS-1:0] model_valid;
    int pred_misses;

    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;
    int cycle_cnt = 0;
    logic [31:0] lfsr_state;

    icache_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp)
    );

    icache_mem_model mem0 (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    always #4 clk = ~clk;

    // outputs sampled mid-cycle away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            if (core_rsp_valid) begin
                rsp_q.push_back(core_rsp.data);
            end
            if (mem_req_valid) begin
                beat_q.push_back(mem_req.addr);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the run hung after %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    // instruction at word address a
    function automatic logic [31:0] rule_word(input word_addr_t a);
        return (32'(a) * 32'h9e37_79b9) ^ 32'hc0de_0000;
    endfunction

    // first beat address of the line holding word a
    function automatic beat_addr_t line_beat(input word_addr_t a);
        beat_addr_t b;
        b = beat_addr_t'(a >> 2);
        return b & ~beat_addr_t'(icache_pkg::BEATS_PER_LINE - 1);
    endfunction

    // taps 32 22 2 1 and one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // direct-mapped lookup where a miss installs the new tag
    task automatic track_access(input word_addr_t a);
        logic [icache_pkg::INDEX_W-1:0] idx;
        logic [icache_pkg::TAG_W-1:0] tag;
        idx = a[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
        tag = a[icache_pkg::CORE_ADDR_W-1 -: icache_pkg::TAG_W];
        if (!(model_valid[idx] && (model_tag[idx] == tag))) begin
            pred_misses++;
            model_valid[idx] = 1'b1;
            model_tag[idx] = tag;
        end
    endtask

    // hold valid until an edge with ready high and return 1 ns after that edge
    task automatic send_req(input word_addr_t a);
        logic accepted;
        accepted = 1'b0;
        core_req_valid = 1'b1;
        core_req.addr = a;
        while (!accepted) begin
            @(negedge clk);
            accepted = core_req_ready;
            @(posedge clk);
            #1;
        end
        core_req_valid = 1'b0;
        sent_q.push_back(a);
        track_access(a);
    endtask

    // wait for one response per request and then one idle cycle for strays
    task automatic collect_rsp(input string name);
        while (rsp_q.size() < sent_q.size()) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        check_eq(name, sent_q.size(), rsp_q.size());
        foreach (sent_q[i]) begin
            if (i < rsp_q.size()) begin
                check_eq(name, rule_word(sent_q[i]), rsp_q[i]);
            end
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        sent_q.delete();
        rsp_q.delete();
        beat_q.delete();
        pred_misses = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - errors_at_start);
        end
    endtask

    // nothing moves before the first request and ready comes up
    task automatic idle_after_reset();
        begin_test();
        @(negedge clk);
        // one cycle in the reset state with ready low
        check_eq("reset_idle", 0, core_req_ready);
        repeat (3) @(negedge clk);
        check_eq("reset_idle", 1, core_req_ready);
        @(posedge clk);
        #1;
        check_eq("reset_idle", 0, rsp_q.size());
        check_eq("reset_idle", 0, beat_q.size());
        end_test("reset_idle");
    endtask

    task automatic cold_miss_fill();
        begin_test();
        send_req(home_addr);
        collect_rsp("cold_miss");
        check_eq("cold_miss", 4, beat_q.size());
        foreach (beat_q[i]) begin
            check_eq("cold_miss", line_beat(home_addr) + i, beat_q[i]);
        end
        end_test("cold_miss");
    endtask

    // whole line as hits with one request per cycle
    task automatic whole_line_hits();
        word_addr_t first;
        int start;
        begin_test();
        first = home_addr & ~word_addr_t'(icache_pkg::LINE_WORDS - 1);
        start = cycle_cnt;
        for (int w = 0; w < icache_pkg::LINE_WORDS; w++) begin
            send_req(first + word_addr_t'(w));
        end
        check_eq("line_hits", icache_pkg::LINE_WORDS, cycle_cnt - start);
        // each hit answers in the cycle after its acceptance
        check_eq("line_hits", icache_pkg::LINE_WORDS - 1, rsp_q.size());
        collect_rsp("line_hits");
        check_eq("line_hits", 0, beat_q.size());
        end_test("line_hits");
    endtask

    // conflicting tag evicts and the way back refills again
    task automatic conflict_eviction();
        begin_test();
        send_req(evict_addr);
        send_req(home_addr);
        collect_rsp("evict");
        check_eq("evict", 8, beat_q.size());
        foreach (beat_q[i]) begin
            check_eq("evict", ((i < 4) ? line_beat(evict_addr) : line_beat(home_addr)) + (i % 4),
                     beat_q[i]);
        end
        end_test("evict");
    endtask

    task automatic random_fetches();
        word_addr_t a;
        begin_test();
        repeat (40) begin
            a = '0;
            for (int b = 0; b < rand_addr_bits; b++) begin
                a[b] = lfsr_bit();
            end
            send_req(a);
        end
        collect_rsp("random");
        check_eq("random", 4 * pred_misses, beat_q.size());
        end_test("random");
    endtask

    initial begin
        rst = 1'b1;
        core_req_valid = 1'b0;
        core_req = '0;
        model_valid = '0;
        lfsr_state = 32'hf274_6041;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_after_reset();
        cold_miss_fill();
        whole_line_hits();
        conflict_eviction();
        random_fetches();
        $display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/icache_pkg.sv
hdl/icache_tag_lookup.sv
hdl/icache_refill.sv
hdl/icache_line_store.sv
hdl/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache regression with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f verilog.f -Mdir obj_dir -o icache_sim > build.log 2>&1 \
    && ./obj_dir/icache_sim > "$log" 2>&1 \
    || { echo "build or simulation did not complete, see build.log and $log"; exit 1; }

cat "$log"

grep -q "Regression failed" "$log" \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }
